// File: sources.f
src/seq_mgr_pkg.sv
src/seq_arbiter.sv
src/local_seq_tracker.sv
src/remote_ack_tracker.sv
src/rx_seq_checker.sv
src/ack_timer.sv
src/seq_mgr.sv
test/seq_mgr_assert.sv
test/seq_mgr_tb.sv

// File: test/seq_mgr_tb.sv
// directed testbench for the sequence/ack manager, plays the tx and rx sides around the DUT
module seq_mgr_tb import seq_mgr_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] ACK_TIMEOUT = 32'd96;
    localparam int POLL_MAX = 50;                  // bound for every handshake poll
    // 11 checks with four polls each, two updates, the timer run, then margin
    localparam int RUN_CYCLES = 8 + 11 * 4 * POLL_MAX + 2 * 8 + ACK_TIMEOUT + 3 * POLL_MAX + 100;

    logic        clk = 1'b0;
    logic        rst_;
    logic        tx2rx_updateseq_req;
    seq_num_t    tx2rx_seq_num;
    logic        tx2rx_updateseq_done;
    logic        chk_req;
    rx_chk_t     chk;
    logic        rx_done;
    logic        accept;
    logic        busy;
    logic        done;
    ack_update_t ack_update;
    logic        updateack_done;
    logic        rtxreq_done;
    send_ack_t   send_ack;
    logic        sendreq_done;
    logic        bcnt_rden;

    // reference model of the link state
    seq_num_t          exp_next;                   // next in-order rx sequence
    seq_num_t          last_acc;                   // last accepted, our ack number
    seq_num_t          ack_cur;                    // remote ack adopted so far
    seq_num_t          ack_max;                    // local sequence cap
    logic [FREE_W-1:0] free_exp;                   // freed entries, held when ack not newer
    int                errors;
    int                checks;
    int                tests;
    int                failed_tests;
    int                test_err0;                  // error count at test start

    always #5 clk = ~clk;

    seq_mgr #(.ACK_TIMEOUT(ACK_TIMEOUT)) uut (.*);

    bind seq_mgr seq_mgr_assert u_assert (
        .clk, .rst_, .ack_update, .send_ack, .sendreq_done, .busy, .done
    );

    // **************************************************
    // helpers
    // **************************************************
    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s = %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors != test_err0) begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - test_err0);
        end else begin
            $display("test %s: ok", name);
        end
        test_err0 = errors;
    endtask

    // update pulse from tx, done comes back on the sixth falling edge
    task automatic set_local_seq(input seq_num_t value);
        tx2rx_seq_num       = value;
        tx2rx_updateseq_req = 1'b1;
        @(negedge clk);
        tx2rx_updateseq_req = 1'b0;
        for (int i = 1; i <= 7; i++) begin
            compare("tx2rx_updateseq_done", tx2rx_updateseq_done, i == 6);
            @(negedge clk);
        end
        if (value > ack_max) begin
            ack_max = value;
        end
    endtask

    // one check request, answers the tx request and finishes with rx_done
    task automatic issue_check(input seq_num_t seq, input seq_num_t ack_num, input logic ack_flag);
        int   n;
        logic acc_exp;
        logic req_exp;
        acc_exp = (seq == exp_next);
        req_exp = !ack_flag || (ack_num >= ack_cur);          // stale ack raises nothing
        if (ack_num > ack_cur) begin
            free_exp = ack_num - ack_cur;
        end
        chk.new_ack_num = ack_num;
        chk.new_seq_num = seq;
        chk.ack         = ack_flag;
        chk_req         = 1'b1;
        n = 0;
        while (!done && n < POLL_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!done) report_fault("check result did not come back");
        compare("accept", accept, acc_exp);
        compare("busy", busy, 1'b1);
        if (req_exp) begin
            n = 0;
            while (!(ack_update.updateack_req | ack_update.rtx_req) && n < POLL_MAX) begin
                @(negedge clk);
                n++;
            end
            compare("ack_update.updateack_req", ack_update.updateack_req, ack_flag);
            compare("ack_update.rtx_req", ack_update.rtx_req, !ack_flag);
            if (ack_flag) compare("ack_update.free_entries", ack_update.free_entries, free_exp);
        end else begin
            @(negedge clk);                                   // result state, no request
            compare("ack_update.updateack_req", ack_update.updateack_req, 1'b0);
        end
        compare("send_ack.ack_mode", send_ack.ack_mode, acc_exp);  // follows the accept
        compare("send_ack.send_req", send_ack.send_req, 1'b0);     // check path sends nothing
        if (req_exp) begin
            updateack_done = ack_flag;
            rtxreq_done    = !ack_flag;
            @(negedge clk);
            updateack_done = 1'b0;
            rtxreq_done    = 1'b0;
            compare("ack_update.updateack_req", ack_update.updateack_req, 1'b0);  // one cycle
            compare("ack_update.rtx_req", ack_update.rtx_req, 1'b0);
        end
        compare("done", done, 1'b1);                          // held until rx finishes
        rx_done = 1'b1;
        chk_req = 1'b0;
        @(negedge clk);
        rx_done = 1'b0;
        n = 0;
        while ((done | busy) && n < POLL_MAX) begin
            @(negedge clk);
            n++;
        end
        if (done | busy) report_fault("check did not release busy and done");
        compare("accept", accept, 1'b0);
        // model update, an accept advances the expected number
        if (acc_exp) begin
            last_acc = seq;
            exp_next = exp_next + 1'b1;
        end
        if (ack_cur <= ack_num && ack_num <= ack_max) begin
            ack_cur = ack_num;
        end
    endtask

    // **************************************************
    // tests
    // **************************************************
    task automatic reset_values();
        compare("tx2rx_updateseq_done", tx2rx_updateseq_done, 1'b0);
        compare("accept", accept, 1'b0);
        compare("busy", busy, 1'b0);
        compare("done", done, 1'b0);
        compare("ack_update.updateack_req", ack_update.updateack_req, 1'b0);
        compare("ack_update.rtx_req", ack_update.rtx_req, 1'b0);
        compare("send_ack.send_req", send_ack.send_req, 1'b0);
        close_test("reset");
    endtask

    task automatic in_order_check();
        issue_check(0, ack_cur, 1'b1);
        issue_check(1, ack_cur, 1'b1);
        issue_check(2, ack_cur, 1'b1);
        issue_check(1, ack_cur, 1'b1);                        // duplicate
        issue_check(5, ack_cur, 1'b1);                        // gap
        close_test("in_order_check");
    endtask

    task automatic seq_update_latency();
        set_local_seq(4);
        close_test("seq_update_latency");
    endtask

    task automatic ack_cap_and_free();
        set_local_seq(10);
        issue_check(exp_next, 5, 1'b1);
        issue_check(exp_next, 8, 1'b1);
        issue_check(exp_next, 20, 1'b1);                      // beyond the cap, not adopted
        issue_check(exp_next, 9, 1'b1);
        issue_check(exp_next, ack_cur, 1'b1);                 // same ack, count holds
        close_test("ack_cap_and_free");
    endtask

    task automatic nack_retransmit();
        issue_check(exp_next, ack_cur, 1'b0);
        close_test("nack_retransmit");
    endtask

    task automatic timer_ack();
        int n;
        bcnt_rden = 1'b1;
        @(negedge clk);
        bcnt_rden = 1'b0;
        n = 0;
        while (!send_ack.send_req && n < ACK_TIMEOUT + 10) begin
            @(negedge clk);
            n++;
        end
        if (!send_ack.send_req) report_fault("no ack send request after the timeout");
        compare("send_ack.ack_mode", send_ack.ack_mode, 1'b1);
        compare("send_ack.rxack_num", send_ack.rxack_num, last_acc);
        repeat (3) begin                                      // tx busy, request must hold
            @(negedge clk);
            compare("send_ack.send_req", send_ack.send_req, 1'b1);
        end
        sendreq_done = 1'b1;
        @(negedge clk);
        sendreq_done = 1'b0;
        n = 0;
        while ((send_ack.send_req | busy) && n < POLL_MAX) begin
            @(negedge clk);
            n++;
        end
        if (send_ack.send_req | busy) report_fault("timer path did not return to idle");
        close_test("timer_ack");
    endtask

    initial begin
        rst_                = 1'b0;
        tx2rx_updateseq_req = 1'b0;
        tx2rx_seq_num       = '0;
        chk_req             = 1'b0;
        chk                 = '0;
        rx_done             = 1'b0;
        updateack_done      = 1'b0;
        rtxreq_done         = 1'b0;
        sendreq_done        = 1'b0;
        bcnt_rden           = 1'b0;
        exp_next            = '0;
        last_acc            = '0;
        ack_cur             = '0;
        ack_max             = '0;
        free_exp            = '0;
        errors              = 0;
        checks              = 0;
        tests               = 0;
        failed_tests        = 0;
        test_err0           = 0;
        repeat (8) @(negedge clk);
        rst_ = 1'b1;
        @(negedge clk);
        reset_values();
        in_order_check();
        seq_update_latency();
        ack_cap_and_free();
        nack_retransmit();
        timer_ack();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog, ends a hung run
    initial begin
        #(RUN_CYCLES * 10);
        $display("watchdog expired, the tests did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: test/seq_mgr_assert.sv
// concurrent protocol checks on the sequence manager ports, bound into the DUT by the testbench
module seq_mgr_assert import seq_mgr_pkg::*; (
    input logic        clk,
    input logic        rst_,
    input ack_update_t ack_update,
    input send_ack_t   send_ack,
    input logic        sendreq_done,
    input logic        busy,
    input logic        done
);

    timeunit 1ns;
    timeprecision 100ps;

    // **************************************************
    // tx request protocol
    // **************************************************
    // free and retransmit requests never together
    req_exclusive: assert property (@(posedge clk) disable iff (!rst_)
        !(ack_update.updateack_req && ack_update.rtx_req))
        else $error("updateack_req and rtx_req high together");

    // ack send request held until the tx side takes it
    send_req_held: assert property (@(posedge clk) disable iff (!rst_)
        (send_ack.send_req && !sendreq_done) |=> send_ack.send_req)
        else $error("send_req dropped before sendreq_done");

    // **************************************************
    // rx side status
    // **************************************************
    done_in_busy: assert property (@(posedge clk) disable iff (!rst_)
        done |-> busy)
        else $error("done high while busy is low");

endmodule

// File: src/seq_mgr.sv
// sequence and ack manager top level for the reliable link layer, connects arbiter, fsms and timer
module seq_mgr import seq_mgr_pkg::*; #(
    parameter logic [31:0] ACK_TIMEOUT = 32'd96
) (
    input  logic        clk,
    input  logic        rst_,
    // local sequence update from tx
    input  logic        tx2rx_updateseq_req,
    input  seq_num_t    tx2rx_seq_num,
    output logic        tx2rx_updateseq_done,
    // sequence check from rx
    input  logic        chk_req,
    input  rx_chk_t     chk,
    input  logic        rx_done,
    output logic        accept,
    output logic        busy,
    output logic        done,
    // tx path requests and answers
    output ack_update_t ack_update,
    input  logic        updateack_done,
    input  logic        rtxreq_done,
    output send_ack_t   send_ack,
    input  logic        sendreq_done,
    input  logic        bcnt_rden         // packet arrival, starts the ack timer
);

    grant_t   grant;
    logic     updateseq_pending;
    logic     us_done;
    logic     sr_done;
    logic     timer_expired;
    seq_num_t ack_num_max;

    seq_arbiter u_arbiter (
        .clk, .rst_,
        .updateseq_req (tx2rx_updateseq_req),
        .chk_req, .timer_expired, .us_done, .sr_done,
        .chk_done      (done),
        .grant, .updateseq_pending
    );

    local_seq_tracker u_local_seq (
        .clk, .rst_, .grant, .updateseq_pending,
        .seq_num        (tx2rx_seq_num),
        .updateseq_req  (tx2rx_updateseq_req),
        .ack_num_max,
        .updateseq_done (tx2rx_updateseq_done),
        .us_done
    );

    remote_ack_tracker u_remote_ack (
        .clk, .rst_, .grant, .chk_req, .chk, .ack_num_max,
        .updateack_done, .rtxreq_done, .ack_update
    );

    rx_seq_checker u_rx_check (
        .clk, .rst_, .grant, .chk, .rx_done, .sendreq_done, .timer_expired,
        .accept, .busy, .done, .send_ack, .sr_done
    );

    ack_timer #(.ACK_TIMEOUT(ACK_TIMEOUT)) u_ack_timer (
        .clk, .rst_, .bcnt_rden, .grant, .timer_expired
    );

endmodule

// File: src/ack_timer.sv
// ack timeout counter, started by packet arrival and cleared by the timer grant
module ack_timer import seq_mgr_pkg::*; #(
    parameter logic [31:0] ACK_TIMEOUT = 32'd96     // cycles from packet to forced ack
) (
    input  logic   clk,
    input  logic   rst_,
    input  logic   bcnt_rden,                       // packet read, starts a count
    input  grant_t grant,
    output logic   timer_expired
);

    logic [31:0] count;
    logic        in_progress;

    // load only when idle, a running count is not restarted
    always_ff @(posedge clk) begin
        if (bcnt_rden & ~in_progress) begin
            count <= ACK_TIMEOUT;
        end else if (in_progress && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            in_progress   <= 1'b0;
            timer_expired <= 1'b0;
        end else begin
            if (timer_expired) begin
                in_progress <= 1'b0;                // expiry ends the count
            end else if (bcnt_rden) begin
                in_progress <= 1'b1;
            end
            if (grant.timer) begin
                timer_expired <= 1'b0;              // ack request under way
            end else if (in_progress && (count == '0)) begin
                timer_expired <= 1'b1;
            end
        end
    end

endmodule

// File: src/rx_seq_checker.sv
// in-order check of received packets and the ack send request on timer expiry
module rx_seq_checker import seq_mgr_pkg::*; (
    input  logic      clk,
    input  logic      rst_,
    input  grant_t    grant,
    input  rx_chk_t   chk,
    input  logic      rx_done,         // rx side finished the packet
    input  logic      sendreq_done,
    input  logic      timer_expired,
    output logic      accept,
    output logic      busy,
    output logic      done,
    output send_ack_t send_ack,
    output logic      sr_done          // done state, to the arbiter
);

    localparam logic [5:0] SR_IDLE  = 6'h01;
    localparam logic [5:0] SR_CHECK = 6'h02;   // compare with the expected number
    localparam logic [5:0] SR_CALC  = 6'h04;   // advance counters, post the result
    localparam logic [5:0] SR_REQ   = 6'h08;   // set up the ack request
    localparam logic [5:0] SR_WAIT  = 6'h10;
    localparam logic [5:0] SR_DONE  = 6'h20;

    logic [5:0] state;
    seq_num_t   seq_cur;                       // last accepted, our ack number
    seq_num_t   seq_next;                      // expected next sequence number
    logic       in_order;
    logic       chk_taken;
    logic       start;

    assign sr_done = state[5];
    assign start   = state[0] & ((grant.chk & ~chk_taken) | (grant.timer & timer_expired));

    // a check grant is served once, the timer path ends by clearing expired
    always_ff @(posedge clk) begin
        if (!rst_) begin
            chk_taken <= 1'b0;
        end else begin
            chk_taken <= grant.chk & (chk_taken | (state[0] & grant.chk));
        end
    end

    // **************************************************
    // check and send-ack fsm
    // **************************************************
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state    <= SR_IDLE;
            seq_cur  <= '0;
            seq_next <= '0;
            in_order <= 1'b0;
            accept   <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            send_ack <= '0;
        end else begin
            case (state)
                SR_IDLE: begin
                    in_order <= 1'b0;
                    accept   <= 1'b0;
                    done     <= 1'b0;
                    busy     <= grant.chk | grant.timer;   // high while a grant is out
                    if (start) begin
                        state <= SR_CHECK;
                    end
                end
                SR_CHECK: begin
                    in_order <= grant.chk & (chk.new_seq_num == seq_next);
                    state    <= SR_CALC;
                end
                SR_CALC: begin
                    if (in_order) begin
                        seq_cur  <= chk.new_seq_num;
                        seq_next <= seq_next + 1'b1;
                    end
                    accept <= in_order;
                    done   <= grant.chk;                   // no result on the timer path
                    state  <= SR_REQ;
                end
                SR_REQ: begin
                    send_ack.send_req  <= grant.timer;     // check path sends nothing
                    send_ack.ack_mode  <= grant.timer | in_order;
                    send_ack.rxack_num <= seq_cur;
                    // rx may finish as soon as the result shows
                    state <= (grant.chk & rx_done) ? SR_DONE : SR_WAIT;
                end
                SR_WAIT: begin
                    if (sendreq_done) begin
                        send_ack.send_req <= 1'b0;
                    end
                    if (sendreq_done | (grant.chk & rx_done)) begin
                        state <= SR_DONE;
                    end
                end
                SR_DONE: begin
                    accept <= 1'b0;
                    done   <= 1'b0;
                    state  <= SR_IDLE;
                end
                default: state <= SR_IDLE;
            endcase
        end
    end

endmodule

// File: src/remote_ack_tracker.sv
// remote ack handling, frees acked rtx entries or asks for a retransmit on nack
module remote_ack_tracker import seq_mgr_pkg::*; (
    input  logic        clk,
    input  logic        rst_,
    input  grant_t      grant,
    input  logic        chk_req,
    input  rx_chk_t     chk,
    input  seq_num_t    ack_num_max,       // newest local seq, upper bound for acks
    input  logic        updateack_done,
    input  logic        rtxreq_done,
    output ack_update_t ack_update
);

    localparam logic [5:0] UA_IDLE  = 6'h01;
    localparam logic [5:0] UA_CHECK = 6'h02;   // latch ack number and mode
    localparam logic [5:0] UA_CALC  = 6'h04;   // freed entry count
    localparam logic [5:0] UA_REQ   = 6'h08;   // updateack or rtx request
    localparam logic [5:0] UA_WAIT  = 6'h10;   // tx path answers, no time limit
    localparam logic [5:0] UA_DONE  = 6'h20;

    logic [5:0] state;
    seq_num_t   ack_num_cur;                   // last adopted remote ack
    seq_num_t   ack_num_new;
    seq_num_t   ack_diff;
    logic       ack_mode;                      // 1 = ack, 0 = nack
    logic       chk_taken;                     // this grant already served
    logic       start;

    assign ack_diff = ack_num_new - ack_num_cur;
    assign start    = state[0] & chk_req & grant.chk & ~chk_taken;

    // one pass per check grant, the grant outlives this machine
    always_ff @(posedge clk) begin
        if (!rst_) begin
            chk_taken <= 1'b0;
        end else begin
            chk_taken <= grant.chk & (chk_taken | start);
        end
    end

    always_ff @(posedge clk) begin
        if (state[1]) begin
            ack_num_new <= chk.new_ack_num;
        end
    end

    // **************************************************
    // ack update fsm
    // **************************************************
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state       <= UA_IDLE;
            ack_update  <= '0;
            ack_num_cur <= '0;
            ack_mode    <= 1'b0;
        end else begin
            case (state)
                UA_IDLE: begin
                    ack_update.updateack_req <= 1'b0;      // free count holds between checks
                    ack_update.rtx_req       <= 1'b0;
                    ack_mode                 <= 1'b0;
                    if (start) begin
                        state <= UA_CHECK;
                    end
                end
                UA_CHECK: begin
                    ack_mode <= chk.ack;
                    state    <= UA_CALC;
                end
                UA_CALC: begin
                    if (ack_num_new > ack_num_cur) begin   // else hold the count
                        ack_update.free_entries <= ack_diff[FREE_W-1:0];
                    end
                    state <= UA_REQ;
                end
                UA_REQ: begin
                    if (!ack_mode) begin
                        ack_update.rtx_req <= 1'b1;
                        state              <= UA_WAIT;
                    end else if (ack_num_new >= ack_num_cur) begin
                        ack_update.updateack_req <= 1'b1;
                        state                    <= UA_WAIT;
                    end else begin
                        state <= UA_DONE;                  // stale ack, nothing to free
                    end
                end
                UA_WAIT: begin
                    ack_update.updateack_req <= 1'b0;      // requests are one-cycle pulses
                    ack_update.rtx_req       <= 1'b0;
                    if ((ack_mode & updateack_done) | (~ack_mode & rtxreq_done)) begin
                        state <= UA_DONE;
                    end
                end
                UA_DONE: begin
                    // adopt only acks between the current one and the local seq cap
                    if ((ack_num_cur <= ack_num_new) && (ack_num_new <= ack_num_max)) begin
                        ack_num_cur <= ack_num_new;
                    end
                    state <= UA_IDLE;
                end
                default: state <= UA_IDLE;
            endcase
        end
    end

endmodule

// File: src/local_seq_tracker.sv
// tracks the highest local tx sequence number, which caps the remote acks that are adopted
module local_seq_tracker import seq_mgr_pkg::*; (
    input  logic     clk,
    input  logic     rst_,
    input  grant_t   grant,
    input  logic     updateseq_pending,
    input  seq_num_t seq_num,            // from tx, valid with the request pulse
    input  logic     updateseq_req,
    output seq_num_t ack_num_max,
    output logic     updateseq_done,     // pulse back to tx
    output logic     us_done             // done state, to the arbiter
);

    localparam logic [3:0] US_IDLE   = 4'h1;
    localparam logic [3:0] US_CHECK  = 4'h2;   // compare the latched number
    localparam logic [3:0] US_UPDATE = 4'h4;   // take it if larger
    localparam logic [3:0] US_DONE   = 4'h8;

    logic [3:0] state;
    seq_num_t   seq_num_reg;                   // number captured on the request pulse
    logic       seq_larger;

    assign us_done = state[3];

    always_ff @(posedge clk) begin
        if (updateseq_req) begin
            seq_num_reg <= seq_num;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            state          <= US_IDLE;
            ack_num_max    <= '0;
            seq_larger     <= 1'b0;
            updateseq_done <= 1'b0;
        end else begin
            case (state)
                US_IDLE: begin
                    updateseq_done <= 1'b0;                    // ends the done pulse
                    if (updateseq_pending & grant.updateseq) begin
                        state <= US_CHECK;
                    end
                end
                US_CHECK: begin
                    seq_larger <= seq_num_reg > ack_num_max;
                    state      <= US_UPDATE;                   // always, for a fixed latency
                end
                US_UPDATE: begin
                    if (seq_larger) begin
                        ack_num_max <= seq_num_reg;
                    end
                    state <= US_DONE;
                end
                US_DONE: begin
                    updateseq_done <= 1'b1;
                    state          <= US_IDLE;
                end
                default: state <= US_IDLE;
            endcase
        end
    end

endmodule

// File: src/seq_arbiter.sv
// master machine of the sequence manager, grants one service at a time and holds seq update pulses
module seq_arbiter import seq_mgr_pkg::*; (
    input  logic   clk,
    input  logic   rst_,
    input  logic   updateseq_req,      // pulse from tx
    input  logic   chk_req,            // level from rx
    input  logic   timer_expired,
    input  logic   us_done,            // seq update machine in done state
    input  logic   sr_done,            // check/send-ack machine in done state
    input  logic   chk_done,           // check result is out
    output grant_t grant,
    output logic   updateseq_pending
);

    localparam logic [2:0] M_IDLE = 3'b001;
    localparam logic [2:0] M_BUSY = 3'b010;
    localparam logic [2:0] M_DONE = 3'b100;   // one cycle to drop the grant

    logic [2:0] state;
    logic       busy_end;

    // end of service depends on which path holds the grant
    assign busy_end = grant.updateseq ? us_done :
                      grant.chk       ? (chk_done & sr_done) :
                      sr_done;             // timer path

    // the update request is a pulse, keep it until it is served
    always_ff @(posedge clk) begin
        if (!rst_) begin
            updateseq_pending <= 1'b0;
        end else if (grant.updateseq) begin
            updateseq_pending <= 1'b0;
        end else if (updateseq_req) begin
            updateseq_pending <= 1'b1;
        end
    end

    // **************************************************
    // master fsm
    // **************************************************
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state <= M_IDLE;
            grant <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (updateseq_pending | timer_expired | chk_req) begin
                        state <= M_BUSY;
                    end
                    // fixed priority, update > timer > check
                    grant.updateseq <= updateseq_pending;
                    grant.timer     <= ~updateseq_pending & timer_expired;
                    grant.chk       <= ~updateseq_pending & ~timer_expired & chk_req;
                end
                M_BUSY: begin
                    if (busy_end) begin
                        state <= M_DONE;
                    end
                end
                M_DONE: begin
                    state <= M_IDLE;
                    grant <= '0;           // machines see idle before the next grant
                end
                default: state <= M_IDLE;
            endcase
        end
    end

endmodule

// File: src/seq_mgr_pkg.sv
// shared widths and port structs of the sequence/ack manager, pulled in by wildcard import
package seq_mgr_pkg;

    localparam int SEQ_W  = 22;            // sequence and ack number width
    localparam int FREE_W = 4;             // freed rtx entries count width

    typedef logic [SEQ_W-1:0] seq_num_t;   // sequence or ack number

    // one-hot service mode of the master machine, only one bit at a time
    typedef struct packed {
        logic updateseq;                   // local sequence update
        logic timer;                       // ack timer expired
        logic chk;                         // rx sequence check
    } grant_t;

    // check request from the receive side, held while chk_req is high
    typedef struct packed {
        seq_num_t new_ack_num;             // remote ack number
        seq_num_t new_seq_num;             // remote sequence number
        logic     ack;                     // 1 = ack, 0 = nack
    } rx_chk_t;

    // requests to the tx path for the retransmit list
    typedef struct packed {
        logic              updateack_req;  // free acked entries, pulse
        logic              rtx_req;        // retransmit, pulse
        logic [FREE_W-1:0] free_entries;   // entries to free from the rtx list
    } ack_update_t;

    // ack send request to the tx path
    typedef struct packed {
        logic     send_req;                // held until sendreq_done
        logic     ack_mode;                // 1 = ack, 0 = nack
        seq_num_t rxack_num;               // local ack number sent to the remote node
    } send_ack_t;

endpackage
